/* sa_cfg_pkg.sv */
package sa_cfg_pkg;

    // Default grid size
    localparam int DEF_ROWS = 4;
    localparam int DEF_COLS = 4;

    localparam int DATA_W = 8;
    // Product width plus headroom for summing DEF_ROWS products
    localparam int ACC_W  = 2 * DATA_W + $clog2(DEF_ROWS);

    typedef logic [DATA_W-1:0] data_t;  // Activations and weights
    typedef logic [ACC_W-1:0]  acc_t;   // Partial sums

endpackage

/* sa_ctl_pkg.sv */
package sa_ctl_pkg;

    // Per-PE multiplier fault codes
    typedef enum logic [1:0] {
        FI_NONE   = 2'd0,
        FI_STUCK0 = 2'd1,   // Product forced to zero
        FI_STUCK1 = 2'd2,   // Product forced to all ones
        FI_FLIP   = 2'd3    // Product bit 0 inverted
    } fault_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_RUN,
        ST_DONE
    } st_state_e;

    localparam int N_TEST_VEC = 3;

    typedef struct packed {
        sa_cfg_pkg::data_t op1;
        sa_cfg_pkg::data_t op2;
        sa_cfg_pkg::acc_t  add;
        sa_cfg_pkg::acc_t  expected;
    } st_vec_t;

    // Odd product, even product, then zero product with a nonzero add
    localparam st_vec_t TEST_VECS [N_TEST_VEC] = '{
        '{op1: 7, op2: 5, add: 3,   expected: 38},
        '{op1: 6, op2: 4, add: 1,   expected: 25},
        '{op1: 0, op2: 9, add: 100, expected: 100}
    };

endpackage

/* stw_bus_if.sv */
`timescale 1ns/1ps

// Self-test vector broadcast from the controller to every PE
interface stw_bus_if;

    sa_cfg_pkg::data_t op1;
    sa_cfg_pkg::data_t op2;
    sa_cfg_pkg::acc_t  add;
    sa_cfg_pkg::acc_t  expected;
    logic              clear;   // Empties the sticky fail flags
    logic              check;   // Compare against expected this cycle

    modport ctrl (output op1, op2, add, expected, clear, check);

    modport pe (input op1, op2, add, expected, clear, check);

endinterface

/* mac_pe.sv */
`timescale 1ns/1ps

module mac_pe (
    input  logic               clk,
    input  logic               rst,
    input  logic               weight_load,
    input  sa_cfg_pkg::data_t  top_weight,
    output sa_cfg_pkg::data_t  down_weight,
    input  sa_cfg_pkg::data_t  left_act,
    output sa_cfg_pkg::data_t  right_act,
    input  sa_cfg_pkg::acc_t   top_psum,
    output sa_cfg_pkg::acc_t   bottom_psum,
    input  sa_ctl_pkg::fault_e fault_inject,
    input  logic               bypass,
    output logic               fail,
    stw_bus_if.pe              st
);

    localparam int PROD_W = 2 * sa_cfg_pkg::DATA_W;

    sa_cfg_pkg::data_t weight;
    sa_cfg_pkg::data_t mul_a;
    sa_cfg_pkg::data_t mul_b;
    logic [PROD_W-1:0] prod;
    sa_cfg_pkg::acc_t  st_result;

    // Stationary weight that also forms one stage of the column load chain
    always_ff @(posedge clk) begin
        if (rst) begin
            weight <= '0;
        end else if (weight_load) begin
            weight <= top_weight;
        end
    end

    assign down_weight = weight;

    // Self-test borrows the multiplier while check is high
    assign mul_a = st.check ? st.op1 : left_act;
    assign mul_b = st.check ? st.op2 : weight;

    always_comb begin
        prod = mul_a * mul_b;
        case (fault_inject)
            sa_ctl_pkg::FI_STUCK0: prod = '0;
            sa_ctl_pkg::FI_STUCK1: prod = '1;
            sa_ctl_pkg::FI_FLIP:   prod[0] = ~prod[0];
            default: ;
        endcase
    end

    assign st_result = sa_cfg_pkg::acc_t'(prod) + st.add;

    always_ff @(posedge clk) begin
        if (rst || st.clear) begin
            fail <= 1'b0;
        end else if (st.check && (st_result != st.expected)) begin
            fail <= 1'b1;   // Sticky until the next clear
        end
    end

    // Bypass keeps the pipeline depth and drops this PE's term
    always_ff @(posedge clk) begin
        right_act <= left_act;
        if (bypass) begin
            bottom_psum <= top_psum;
        end else begin
            bottom_psum <= top_psum + sa_cfg_pkg::acc_t'(prod);
        end
    end

endmodule

/* skew_line.sv */
`timescale 1ns/1ps

module skew_line #(
    parameter int  LANES     = 4,
    parameter bit  REVERSE   = 1'b0,
    parameter type payload_t = sa_cfg_pkg::data_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_in,
    input  payload_t lanes_in  [LANES],
    output payload_t lanes_out [LANES],
    output logic     valid_out
);

    logic [LANES-1:0] valid_sr;

    // Valid chain is LANES deep in both modes
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= valid_in;
            for (int k = 1; k < LANES; k++) begin
                valid_sr[k] <= valid_sr[k-1];
            end
        end
    end

    assign valid_out = valid_sr[LANES-1];

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        localparam int DEPTH = REVERSE ? (LANES - i) : i;

        if (DEPTH == 0) begin : g_wire
            assign lanes_out[i] = lanes_in[i];
        end else begin : g_sr
            payload_t sr [DEPTH];

            always_ff @(posedge clk) begin
                sr[0] <= lanes_in[i];
                for (int k = 1; k < DEPTH; k++) begin
                    sr[k] <= sr[k-1];
                end
            end

            assign lanes_out[i] = sr[DEPTH-1];
        end
    end

endmodule

/* systolic_array.sv */
`timescale 1ns/1ps

module systolic_array #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               weight_load,
    input  sa_cfg_pkg::data_t  weight_in    [COLS],
    input  sa_cfg_pkg::data_t  act_in       [ROWS],
    output sa_cfg_pkg::acc_t   psum_out     [COLS],
    input  sa_ctl_pkg::fault_e fault_inject [ROWS][COLS],
    input  logic               bypass       [ROWS][COLS],
    output logic               fail         [ROWS][COLS],
    stw_bus_if.pe              st
);

    // One extra row/column so edge PEs need no special case
    sa_cfg_pkg::data_t w_bus [ROWS+1][COLS];
    sa_cfg_pkg::data_t a_bus [ROWS][COLS+1];
    sa_cfg_pkg::acc_t  p_bus [ROWS+1][COLS];

    for (genvar c = 0; c < COLS; c++) begin : g_col_edge
        assign w_bus[0][c] = weight_in[c];
        assign p_bus[0][c] = '0;
        assign psum_out[c] = p_bus[ROWS][c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row_edge
        assign a_bus[r][0] = act_in[r];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            mac_pe u_pe (
                .clk          (clk),
                .rst          (rst),
                .weight_load  (weight_load),
                .top_weight   (w_bus[r][c]),
                .down_weight  (w_bus[r+1][c]),
                .left_act     (a_bus[r][c]),
                .right_act    (a_bus[r][c+1]),
                .top_psum     (p_bus[r][c]),
                .bottom_psum  (p_bus[r+1][c]),
                .fault_inject (fault_inject[r][c]),
                .bypass       (bypass[r][c]),
                .fail         (fail[r][c]),
                .st           (st)
            );
        end
    end

endmodule

/* self_test_ctrl.sv */
`timescale 1ns/1ps

module self_test_ctrl #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    st_req,
    output logic    st_ack,
    output logic    st_busy,
    input  logic    fail      [ROWS][COLS],
    output logic    fault_map [ROWS][COLS],
    stw_bus_if.ctrl st
);

    localparam int IDX_W = $clog2(sa_ctl_pkg::N_TEST_VEC);

    sa_ctl_pkg::st_state_e state;
    logic [IDX_W-1:0]      vec_idx;
    sa_ctl_pkg::st_vec_t   cur_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= sa_ctl_pkg::ST_IDLE;
            vec_idx   <= '0;
            st_ack    <= 1'b0;
            fault_map <= '{default: 1'b0};
        end else begin
            case (state)
                sa_ctl_pkg::ST_IDLE: begin
                    if (!st_req) begin
                        st_ack <= 1'b0;     // Closes the four-phase cycle
                    end else if (!st_ack) begin
                        state <= sa_ctl_pkg::ST_CLEAR;
                    end
                end
                sa_ctl_pkg::ST_CLEAR: begin
                    vec_idx <= '0;
                    state   <= sa_ctl_pkg::ST_RUN;
                end
                sa_ctl_pkg::ST_RUN: begin
                    if (vec_idx == IDX_W'(sa_ctl_pkg::N_TEST_VEC - 1)) begin
                        state <= sa_ctl_pkg::ST_DONE;
                    end else begin
                        vec_idx <= vec_idx + 1'b1;
                    end
                end
                sa_ctl_pkg::ST_DONE: begin
                    // Last compare has landed in the fail flags by now
                    fault_map <= fail;
                    st_ack    <= 1'b1;
                    state     <= sa_ctl_pkg::ST_IDLE;
                end
                default: state <= sa_ctl_pkg::ST_IDLE;
            endcase
        end
    end

    // Busy also covers a request that has not been taken yet
    assign st_busy = (state != sa_ctl_pkg::ST_IDLE) || (st_req && !st_ack);

    assign cur_vec     = sa_ctl_pkg::TEST_VECS[vec_idx];
    assign st.op1      = cur_vec.op1;
    assign st.op2      = cur_vec.op2;
    assign st.add      = cur_vec.add;
    assign st.expected = cur_vec.expected;
    assign st.clear    = (state == sa_ctl_pkg::ST_CLEAR);
    assign st.check    = (state == sa_ctl_pkg::ST_RUN);

endmodule

/* stw_systolic_top.sv */
`timescale 1ns/1ps

// psum_valid rises on the (ROWS+COLS)-th rising edge counted from, and
// including, the edge that samples act_valid
module stw_systolic_top #(
    parameter int ROWS = sa_cfg_pkg::DEF_ROWS,
    parameter int COLS = sa_cfg_pkg::DEF_COLS
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                weight_load,
    input  logic [COLS*sa_cfg_pkg::DATA_W-1:0]  weight_in,
    input  logic                                act_valid,
    input  logic [ROWS*sa_cfg_pkg::DATA_W-1:0]  act_in,
    output logic                                psum_valid,
    output logic [COLS*sa_cfg_pkg::ACC_W-1:0]   psum_out,
    input  logic [ROWS*COLS*2-1:0]              fault_inject,
    input  logic                                st_req,
    output logic                                st_ack,
    output logic                                st_busy,
    output logic [ROWS*COLS-1:0]                fault_map
);

    localparam int DW = sa_cfg_pkg::DATA_W;
    localparam int AW = sa_cfg_pkg::ACC_W;

    sa_cfg_pkg::data_t  w_arr     [COLS];
    sa_cfg_pkg::data_t  act_arr   [ROWS];
    sa_cfg_pkg::data_t  act_skew  [ROWS];
    sa_cfg_pkg::acc_t   psum_arr  [COLS];
    sa_cfg_pkg::acc_t   psum_dsk  [COLS];
    sa_ctl_pkg::fault_e fi_arr    [ROWS][COLS];
    logic               fail_arr  [ROWS][COLS];
    logic               fmap_arr  [ROWS][COLS];
    logic               skew_valid;

    stw_bus_if st_bus ();

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        assign act_arr[r] = act_in[r*DW +: DW];
        for (genvar c = 0; c < COLS; c++) begin : g_col
            assign fi_arr[r][c] = sa_ctl_pkg::fault_e'(fault_inject[(r*COLS+c)*2 +: 2]);
            assign fault_map[r*COLS+c] = fmap_arr[r][c];
        end
    end

    for (genvar c = 0; c < COLS; c++) begin : g_col_io
        assign w_arr[c]            = weight_in[c*DW +: DW];
        assign psum_out[c*AW +: AW] = psum_dsk[c];
    end

    skew_line #(
        .LANES     (ROWS),
        .REVERSE   (1'b0),
        .payload_t (sa_cfg_pkg::data_t)
    ) u_in_skew (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (act_valid),
        .lanes_in  (act_arr),
        .lanes_out (act_skew),
        .valid_out (skew_valid)
    );

    systolic_array #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_array (
        .clk          (clk),
        .rst          (rst),
        .weight_load  (weight_load),
        .weight_in    (w_arr),
        .act_in       (act_skew),
        .psum_out     (psum_arr),
        .fault_inject (fi_arr),
        .bypass       (fmap_arr),   // Faulty PEs are bypassed
        .fail         (fail_arr),
        .st           (st_bus.pe)
    );

    skew_line #(
        .LANES     (COLS),
        .REVERSE   (1'b1),
        .payload_t (sa_cfg_pkg::acc_t)
    ) u_out_deskew (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (skew_valid),
        .lanes_in  (psum_arr),
        .lanes_out (psum_dsk),
        .valid_out (psum_valid)
    );

    self_test_ctrl #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_st_ctrl (
        .clk       (clk),
        .rst       (rst),
        .st_req    (st_req),
        .st_ack    (st_ack),
        .st_busy   (st_busy),
        .fail      (fail_arr),
        .fault_map (fmap_arr),
        .st        (st_bus.ctrl)
    );

endmodule

/* tb_stw_systolic.sv */
`timescale 1ns/1ps

module tb_stw_systolic;

    localparam int ROWS = sa_cfg_pkg::DEF_ROWS;
    localparam int COLS = sa_cfg_pkg::DEF_COLS;
    localparam int DW   = sa_cfg_pkg::DATA_W;
    localparam int AW   = sa_cfg_pkg::ACC_W;
    localparam int LAT  = ROWS + COLS;
    localparam int NV   = sa_ctl_pkg::N_TEST_VEC;

    logic                   clk;
    logic                   rst;
    logic                   weight_load;
    logic [COLS*DW-1:0]     weight_in;
    logic                   act_valid;
    logic [ROWS*DW-1:0]     act_in;
    logic                   psum_valid;
    logic [COLS*AW-1:0]     psum_out;
    logic [ROWS*COLS*2-1:0] fault_inject;
    logic                   st_req;
    logic                   st_ack;
    logic                   st_busy;
    logic [ROWS*COLS-1:0]   fault_map;

    int cycle = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int wd_cycles = 0;
    int vec_id = 0;

    // Pending results with the oldest at the front
    logic [COLS*AW-1:0] exp_q [$];
    int                 start_q [$];
    int                 id_q [$];

    stw_systolic_top u_stw_systolic_top (
        .clk          (clk),
        .rst          (rst),
        .weight_load  (weight_load),
        .weight_in    (weight_in),
        .act_valid    (act_valid),
        .act_in       (act_in),
        .psum_valid   (psum_valid),
        .psum_out     (psum_out),
        .fault_inject (fault_inject),
        .st_req       (st_req),
        .st_ack       (st_ack),
        .st_busy      (st_busy),
        .fault_map    (fault_map)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string label, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("PASS  %s", label);
        end else begin
            tests_failed++;
            $display("FAIL  %s", label);
        end
    endtask

    task automatic read_hex(input int fd, output logic [31:0] val);
        logic [31:0] tmp;
        int          n;
        tmp = '0;
        n = $fscanf(fd, "%h", tmp);
        if (n != 1) begin
            $display("Trace line is malformed near time %0t", $time);
            errors++;
        end
        val = tmp;
    endtask

    // Waits for every vector in flight to come out
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < LAT + 4) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d vector results never appeared on psum_out", exp_q.size());
            errors++;
            exp_q.delete();
            start_q.delete();
            id_q.delete();
        end
    endtask

    task automatic self_test(input logic [ROWS*COLS-1:0] exp_map);
        int errs_before;
        int waited;
        errs_before = errors;
        waited = 0;
        st_req = 1'b1;
        @(negedge clk);
        while (!st_ack && waited < NV + 10) begin
            check_value("st_busy", 1, st_busy);   // High until the ack
            @(negedge clk);
            waited++;
        end
        if (!st_ack) begin
            $display("st_ack did not rise within %0d cycles of st_req", NV + 10);
            errors++;
        end
        check_value("fault_map", exp_map, fault_map);
        @(posedge clk);
        #2;
        st_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (st_ack && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (st_ack) begin
            $display("st_ack stayed high after st_req was lowered");
            errors++;
        end
        check_value("st_busy", 0, st_busy);
        @(posedge clk);
        #2;
        finish_test($sformatf("self-test, fault map %h", exp_map), errs_before);
    endtask

    task automatic run_trace(input int fd);
        logic [7:0]         cmd;
        logic [31:0]        val;
        logic [COLS*DW-1:0] w_v;
        logic [ROWS*DW-1:0] act_v;
        logic [COLS*AW-1:0] exp_v;
        int                 n;
        int                 ch;
        bit                 done;
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1) begin
                $display("Trace ended without an E line");
                errors++;
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": begin
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) ch = $fgetc(fd);
                    end
                    "W": begin
                        drain();
                        for (int c = 0; c < COLS; c++) begin
                            read_hex(fd, val);
                            w_v[c*DW +: DW] = val[DW-1:0];
                        end
                        weight_in   = w_v;
                        weight_load = 1'b1;
                        @(posedge clk);
                        #2;
                        weight_load = 1'b0;
                    end
                    "A": begin
                        for (int r = 0; r < ROWS; r++) begin
                            read_hex(fd, val);
                            act_v[r*DW +: DW] = val[DW-1:0];
                        end
                        for (int c = 0; c < COLS; c++) begin
                            read_hex(fd, val);
                            exp_v[c*AW +: AW] = val[AW-1:0];
                        end
                        act_in    = act_v;
                        act_valid = 1'b1;
                        exp_q.push_back(exp_v);
                        start_q.push_back(cycle);
                        id_q.push_back(vec_id);
                        vec_id++;
                        @(posedge clk);
                        #2;
                        act_valid = 1'b0;   // A following A line raises it again
                    end
                    "F": begin
                        drain();
                        read_hex(fd, val);
                        fault_inject = val[ROWS*COLS*2-1:0];
                    end
                    "T": begin
                        drain();
                        read_hex(fd, val);
                        self_test(val[ROWS*COLS-1:0]);
                    end
                    "E": begin
                        drain();
                        done = 1'b1;
                    end
                    default: begin
                        $display("Unknown trace command '%c'", cmd);
                        errors++;
                        done = 1'b1;
                    end
                endcase
            end
        end
    endtask

    // Results are sampled mid-cycle
    always @(negedge clk) begin : result_check
        logic [COLS*AW-1:0] exp_v;
        int                 start;
        int                 id;
        int                 errs_before;
        if (!rst && psum_valid) begin
            if (exp_q.size() == 0) begin
                $display("psum_valid went high at %0t with no vector in flight", $time);
                errors++;
            end else begin
                exp_v       = exp_q.pop_front();
                start       = start_q.pop_front();
                id          = id_q.pop_front();
                errs_before = errors;
                for (int c = 0; c < COLS; c++) begin
                    check_value($sformatf("psum_out[%0d]", c), exp_v[c*AW +: AW],
                                psum_out[c*AW +: AW]);
                end
                check_value("psum_valid latency", LAT, cycle - start);
                finish_test($sformatf("vector %0d", id), errs_before);
            end
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the trace did not finish within %0d cycles", wd_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int fd;
        int ch;
        int n_lines;
        int errs_before;
        rst          = 1'b1;
        weight_load  = 1'b0;
        weight_in    = '0;
        act_valid    = 1'b0;
        act_in       = '0;
        fault_inject = '0;
        st_req       = 1'b0;
        n_lines      = 0;
        fd = $fopen("systolic_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open systolic_trace.txt");
            errors++;
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == 10) n_lines++;
                ch = $fgetc(fd);
            end
            $fclose(fd);
            fd = $fopen("systolic_trace.txt", "r");
            wd_cycles = n_lines * (LAT + NV + 10) + 50;
            repeat (10) @(posedge clk);
            #2;
            rst = 1'b0;
            errs_before = errors;
            @(negedge clk);
            check_value("psum_valid", 0, psum_valid);
            check_value("st_ack", 0, st_ack);
            check_value("st_busy", 0, st_busy);
            check_value("fault_map", 0, fault_map);
            finish_test("outputs after reset", errs_before);
            @(posedge clk);
            #2;
            run_trace(fd);
            $fclose(fd);
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && tests_run > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* systolic_trace.txt */
# W w0..w3 | A a0..a3 then expected psum 0..3 | F fault word | T fault map | E end
# All fields hex, the first of four W lines ends in the bottom row
W 0a 0b 0c ff
W 07 08 09 ff
W 04 05 06 ff
W 01 02 03 ff
A 01 00 00 00 00001 00002 00003 000ff
F 00000000
A 01 02 03 04 00046 00050 0005a 009f6
A ff ff ff ff 015ea 019e6 01de2 3f804
A 02 00 01 03 00027 0002d 00033 005fa
A 00 03 00 05 0003e 00046 0004e 007f8
A 10 01 02 00 00022 00035 00048 012ed
F 43308004
T 9482
A 01 02 03 04 0001e 0004e 0003f 003fc
A ff ff ff ff 00bf4 017e8 014eb 1fc02
A 02 00 01 03 00009 00029 0002a 002fd
A 10 01 02 00 00022 00015 00036 011ee
F 00000000
T 0000
A 01 02 03 04 00046 00050 0005a 009f6
A ff ff ff ff 015ea 019e6 01de2 3f804
A 00 03 00 05 0003e 00046 0004e 007f8
E

/* build.f */
sa_cfg_pkg.sv
sa_ctl_pkg.sv
stw_bus_if.sv
mac_pe.sv
skew_line.sv
systolic_array.sv
self_test_ctrl.sv
stw_systolic_top.sv
tb_stw_systolic.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_stw_systolic
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TRACE     ?= systolic_trace.txt
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN) $(TRACE)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
